/* Makefile */
# Verilator build and run for the CLIC CSR testbench

VERILATOR ?= verilator
TOP ?= clic_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

# pass only when the testbench printed its pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR)

/* design/clic_int_table.sv */
// Interrupt vector table and arbiter
`timescale 1ns/100ps
`default_nettype none

module clic_int_table #(
  parameter int VecSize = 8
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic csr_en,
  input wire decoder_pkg::csr_req_t csr_bus,
  input wire logic [VecSize-1:0] irq_lines,
  input wire logic timer_irq,
  output decoder_pkg::word rd_data,
  output clic_pkg::int_sel_t sel
);

  localparam int IdxWidth = (VecSize > 1) ? $clog2(VecSize) : 1;

  clic_pkg::csr_data_u cfg [VecSize];
  clic_pkg::csr_data_u cfg_next [VecSize];
  // sampled interrupt levels
  logic [VecSize-1:0] lines_q;
  decoder_pkg::csr_addr_t offset;
  logic [IdxWidth-1:0] idx;
  logic hit;

  // vector index from the address
  assign offset = csr_bus.addr - clic_pkg::int_cfg_base;
  assign idx = offset[IdxWidth-1:0];
  // addresses below the base wrap high and miss too
  assign hit = offset < 12'(VecSize);

  // timer shares vector 0
  always_ff @(posedge clk) begin
    if (rst) begin
      lines_q <= '0;
    end else begin
      lines_q <= irq_lines | {{(VecSize-1){1'b0}}, timer_irq};
    end
  end

  always_comb begin
    for (int i = 0; i < VecSize; i++) begin
      cfg_next[i] = cfg[i];
      if (csr_en && hit && idx == IdxWidth'(i)) begin
        cfg_next[i].raw = decoder_pkg::csr_apply(cfg[i].raw, csr_bus.op,
                                                 csr_bus.rs1_zimm, csr_bus.rs1_data);
      end
      // a high level beats a software clear
      if (lines_q[i]) begin
        cfg_next[i].cfg.pending = 1'b1;
      end
      // reserved bits always read zero
      cfg_next[i].cfg.reserved = '0;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < VecSize; i++) begin
      if (rst) begin
        cfg[i].raw <= '0;
      end else begin
        cfg[i] <= cfg_next[i];
      end
    end
  end

  assign rd_data = hit ? cfg[idx].raw : '0;

  // strict compare, so the lowest index keeps a tie
  always_comb begin
    sel = '0;
    for (int i = 0; i < VecSize; i++) begin
      if (cfg[i].cfg.enable && cfg[i].cfg.pending &&
          (!sel.any || cfg[i].cfg.prio > sel.prio)) begin
        sel.any = 1'b1;
        sel.id = 8'(i);
        sel.prio = cfg[i].cfg.prio;
      end
    end
  end

endmodule

`default_nettype wire

/* design/clic_pkg.sv */
// Interrupt controller types and address map
`default_nettype none

package clic_pkg;

  // machine CSRs
  localparam decoder_pkg::csr_addr_t mstatus_addr = 12'h300;
  localparam decoder_pkg::csr_addr_t mintthresh_addr = 12'h347;
  localparam decoder_pkg::csr_addr_t stack_depth_addr = 12'h350;
  // first per-vector config word, one address per vector
  localparam decoder_pkg::csr_addr_t int_cfg_base = 12'hB00;
  // timer
  localparam decoder_pkg::csr_addr_t timer_cmp_addr = 12'hD00;
  localparam decoder_pkg::csr_addr_t timer_cnt_addr = 12'hD01;

  // reset values
  localparam decoder_pkg::word stack_depth_reset = 32'd8;
  localparam decoder_pkg::word mintthresh_reset = 32'd0;

  // global interrupt enable in mstatus
  localparam int mie_bit = 3;

  // field view of one vector config word
  typedef struct packed {
    logic [21:0] reserved;
    logic [7:0] prio;
    logic enable;
    logic pending;
  } int_cfg_t;

  // same word, raw for CSR access or decoded for arbitration
  typedef union packed {
    decoder_pkg::word raw;
    int_cfg_t cfg;
  } csr_data_u;

  // interrupt presented to the core
  typedef struct packed {
    logic valid;
    logic [7:0] id;
    logic [7:0] level;
  } irq_t;

  // arbiter winner
  typedef struct packed {
    logic any;
    logic [7:0] id;
    logic [7:0] prio;
  } int_sel_t;

endpackage

`default_nettype wire

/* design/clic_timer.sv */
// CLIC timer
`timescale 1ns/100ps
`default_nettype none

module clic_timer (
  input wire logic clk,
  input wire logic rst,
  input wire logic csr_en,
  input wire decoder_pkg::csr_req_t csr_bus,
  output decoder_pkg::word rd_data,
  output logic timer_irq
);

  decoder_pkg::word count;
  decoder_pkg::word compare;
  logic cmp_hit;
  logic expired;

  assign cmp_hit = csr_bus.addr == clic_pkg::timer_cmp_addr;
  // compare of zero keeps the timer idle
  assign expired = (compare != '0) && (count == compare);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      compare <= '0;
      timer_irq <= 1'b0;
    end else begin
      // compare is the only writable timer CSR
      if (csr_en && cmp_hit) begin
        compare <= decoder_pkg::csr_apply(compare, csr_bus.op, csr_bus.rs1_zimm,
                                          csr_bus.rs1_data);
      end
      // one-cycle pulse, reload to zero
      timer_irq <= expired;
      count <= expired ? '0 : count + 32'd1;
    end
  end

  // count is read-only
  always_comb begin
    case (csr_bus.addr)
      clic_pkg::timer_cmp_addr: rd_data = compare;
      clic_pkg::timer_cnt_addr: rd_data = count;
      default: rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/clic_top.sv */
// CLIC CSR top level
`timescale 1ns/100ps
`default_nettype none

module clic_top #(
  parameter int VecSize = 8
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic req,
  output logic ack,
  input wire decoder_pkg::csr_req_t req_data,
  output decoder_pkg::word rdata,
  input wire logic [VecSize-1:0] irq_lines,
  output clic_pkg::irq_t irq
);

  // shared CSR bus
  logic csr_en;
  decoder_pkg::csr_req_t csr_bus;
  decoder_pkg::word bank_rd;
  decoder_pkg::word table_rd;
  decoder_pkg::word timer_rd;
  clic_pkg::int_sel_t sel;
  logic timer_irq;

  csr_access_fsm u_fsm (
    .clk(clk),
    .rst(rst),
    .req(req),
    .ack(ack),
    .req_data(req_data),
    .csr_en(csr_en),
    .csr_bus(csr_bus),
    .rd_data(bank_rd),
    .rdata(rdata)
  );

  // bank also muxes table and timer reads
  n_clic #(
    .VecSize(VecSize)
  ) u_bank (
    .clk(clk),
    .rst(rst),
    .csr_en(csr_en),
    .csr_bus(csr_bus),
    .table_rd(table_rd),
    .timer_rd(timer_rd),
    .sel(sel),
    .rd_data(bank_rd),
    .irq(irq)
  );

  clic_int_table #(
    .VecSize(VecSize)
  ) u_table (
    .clk(clk),
    .rst(rst),
    .csr_en(csr_en),
    .csr_bus(csr_bus),
    .irq_lines(irq_lines),
    .timer_irq(timer_irq),
    .rd_data(table_rd),
    .sel(sel)
  );

  clic_timer u_timer (
    .clk(clk),
    .rst(rst),
    .csr_en(csr_en),
    .csr_bus(csr_bus),
    .rd_data(timer_rd),
    .timer_irq(timer_irq)
  );

endmodule

`default_nettype wire

/* design/csr.sv */
// Single CSR register
`timescale 1ns/100ps
`default_nettype none

module csr #(
  parameter decoder_pkg::csr_addr_t Addr = '0,
  parameter decoder_pkg::word ResetValue = '0,
  parameter bit Read = 1'b1,
  parameter bit Write = 1'b1
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic en,
  input wire decoder_pkg::csr_addr_t addr,
  input wire decoder_pkg::r rs1_zimm,
  input wire decoder_pkg::word rs1_data,
  input wire decoder_pkg::csr_t op,
  output decoder_pkg::word out
);

  decoder_pkg::word value;
  logic match;

  // own address only
  assign match = addr == Addr;

  // update lands on the edge closing the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      value <= ResetValue;
    end else if (en && match && Write) begin
      value <= decoder_pkg::csr_apply(value, op, rs1_zimm, rs1_data);
    end
  end

  // old value is visible during the strobe cycle
  // zero when not addressed, so outputs can be muxed freely
  assign out = (match && Read) ? value : '0;

endmodule

`default_nettype wire

/* design/csr_access_fsm.sv */
// CSR access handshake FSM
`timescale 1ns/100ps
`default_nettype none

module csr_access_fsm (
  input wire logic clk,
  input wire logic rst,
  input wire logic req,
  output logic ack,
  input wire decoder_pkg::csr_req_t req_data,
  output logic csr_en,
  output decoder_pkg::csr_req_t csr_bus,
  input wire decoder_pkg::word rd_data,
  output decoder_pkg::word rdata
);

  // idle -> exec (one strobe cycle) -> hold (ack high)
  typedef enum logic [1:0] {idle, exec, hold} state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (req) begin
            state <= exec;
          end
        end
        exec: begin
          state <= hold;
        end
        // wait for the core to drop req
        hold: begin
          if (!req) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // bus frozen for the whole access
  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      csr_bus <= req_data;
    end
    // old CSR value, before the write lands
    if (state == exec) begin
      rdata <= rd_data;
    end
  end

  assign csr_en = state == exec;
  // ack falls on the edge that sees req low
  assign ack = state == hold;

endmodule

`default_nettype wire

/* design/decoder_pkg.sv */
// CSR instruction decode types
`default_nettype none

package decoder_pkg;

  // basic data and address widths
  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;
  // register index, doubles as zimm for the immediate ops
  typedef logic [4:0] r;

  // csrrw, csrrs, csrrc and their immediate forms
  typedef enum logic [2:0] {rw, rs, rc, rwi, rsi, rci} csr_t;

  // one CSR access as issued by the core
  typedef struct packed {
    csr_addr_t addr;
    csr_t op;
    r rs1_zimm;
    word rs1_data;
  } csr_req_t;

  // new CSR value from old value and operands
  function automatic word csr_apply(word old, csr_t op, r zimm, word rs1_data);
    word src;
    // immediate forms zero-extend zimm
    src = (op inside {rwi, rsi, rci}) ? {27'b0, zimm} : rs1_data;
    case (op)
      rw, rwi: return src;
      // zero source leaves the value as is
      rs, rsi: return old | src;
      rc, rci: return old & ~src;
      default: return old;
    endcase
  endfunction

endpackage

`default_nettype wire

/* design/n_clic.sv */
// Machine CSR bank and interrupt gating
`timescale 1ns/100ps
`default_nettype none

module n_clic #(
  parameter int VecSize = 8
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic csr_en,
  input wire decoder_pkg::csr_req_t csr_bus,
  input wire decoder_pkg::word table_rd,
  input wire decoder_pkg::word timer_rd,
  input wire clic_pkg::int_sel_t sel,
  output decoder_pkg::word rd_data,
  output clic_pkg::irq_t irq
);

  decoder_pkg::word mstatus_rd;
  decoder_pkg::word thresh_rd;
  decoder_pkg::word depth_rd;
  decoder_pkg::word mstatus_old;
  decoder_pkg::word thresh_old;
  decoder_pkg::word mstatus_new;
  decoder_pkg::word thresh_new;
  // local copies for gating, updated by the same writes
  logic mie_q;
  logic [7:0] thresh_q;
  logic table_hit;

  csr #(
    .Addr(clic_pkg::mstatus_addr),
    .ResetValue('0)
  ) mstatus (
    .clk(clk),
    .rst(rst),
    .en(csr_en),
    .addr(csr_bus.addr),
    .rs1_zimm(csr_bus.rs1_zimm),
    .rs1_data(csr_bus.rs1_data),
    .op(csr_bus.op),
    .out(mstatus_rd)
  );

  csr #(
    .Addr(clic_pkg::mintthresh_addr),
    .ResetValue(clic_pkg::mintthresh_reset)
  ) mintthresh (
    .clk(clk),
    .rst(rst),
    .en(csr_en),
    .addr(csr_bus.addr),
    .rs1_zimm(csr_bus.rs1_zimm),
    .rs1_data(csr_bus.rs1_data),
    .op(csr_bus.op),
    .out(thresh_rd)
  );

  // read-only, writes dropped
  csr #(
    .Addr(clic_pkg::stack_depth_addr),
    .ResetValue(clic_pkg::stack_depth_reset),
    .Write(1'b0)
  ) stack_depth (
    .clk(clk),
    .rst(rst),
    .en(csr_en),
    .addr(csr_bus.addr),
    .rs1_zimm(csr_bus.rs1_zimm),
    .rs1_data(csr_bus.rs1_data),
    .op(csr_bus.op),
    .out(depth_rd)
  );

  // csr_apply is bitwise, so the tracked bits alone are enough
  assign mstatus_old = 32'(mie_q) << clic_pkg::mie_bit;
  assign thresh_old = {24'b0, thresh_q};
  assign mstatus_new = decoder_pkg::csr_apply(mstatus_old, csr_bus.op, csr_bus.rs1_zimm,
                                              csr_bus.rs1_data);
  assign thresh_new = decoder_pkg::csr_apply(thresh_old, csr_bus.op, csr_bus.rs1_zimm,
                                             csr_bus.rs1_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      mie_q <= 1'b0;
      thresh_q <= clic_pkg::mintthresh_reset[7:0];
    end else if (csr_en) begin
      if (csr_bus.addr == clic_pkg::mstatus_addr) begin
        mie_q <= mstatus_new[clic_pkg::mie_bit];
      end
      if (csr_bus.addr == clic_pkg::mintthresh_addr) begin
        thresh_q <= thresh_new[7:0];
      end
    end
  end

  // vector table window
  assign table_hit = (csr_bus.addr - clic_pkg::int_cfg_base) < 12'(VecSize);

  // unmapped addresses fall to zero
  always_comb begin
    if (table_hit) begin
      rd_data = table_rd;
    end else begin
      case (csr_bus.addr)
        clic_pkg::mstatus_addr: rd_data = mstatus_rd;
        clic_pkg::mintthresh_addr: rd_data = thresh_rd;
        clic_pkg::stack_depth_addr: rd_data = depth_rd;
        clic_pkg::timer_cmp_addr, clic_pkg::timer_cnt_addr: rd_data = timer_rd;
        default: rd_data = '0;
      endcase
    end
  end

  // registered, one cycle behind any change
  always_ff @(posedge clk) begin
    if (rst) begin
      irq <= '0;
    end else begin
      irq.valid <= mie_q && sel.any && (sel.prio > thresh_q);
      irq.id <= sel.id;
      irq.level <= sel.prio;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
design/decoder_pkg.sv
design/clic_pkg.sv
design/csr.sv
design/csr_access_fsm.sv
design/clic_timer.sv
design/clic_int_table.sv
design/n_clic.sv
design/clic_top.sv
sim/clic_tb.sv

/* sim/clic_golden.txt */
# op addr wdata irq_lines exp_rdata exp_valid exp_id check, all hex
# op 0-5 = rw rs rc rwi rsi rci; check 0 = equal, 1 = below, 2 = poll until equal
1 350 00000000 00 00000008 0 00 0
1 300 00000000 00 00000000 0 00 0
1 347 00000000 00 00000000 0 00 0
1 b00 00000000 00 00000000 0 00 0
1 b07 00000000 00 00000000 0 00 0
1 d00 00000000 00 00000000 0 00 0
1 123 00000000 00 00000000 0 00 0
0 b00 00000002 00 00000000 0 00 0
0 d00 00000180 00 00000000 0 00 0
1 d01 00000000 00 00000180 0 00 1
1 b00 00000000 00 00000003 0 00 2
0 d00 00000000 00 00000180 0 00 0
0 b00 00000000 00 00000003 0 00 0
0 300 a5a5a5a0 00 00000000 0 00 0
1 300 0000000f 00 a5a5a5a0 0 00 0
2 300 a0000003 00 a5a5a5af 0 00 0
1 300 00000000 00 05a5a5ac 0 00 0
3 300 ffffffd5 00 05a5a5ac 0 00 0
4 300 0000000a 00 00000015 0 00 0
5 300 0000000f 00 0000001f 0 00 0
5 300 00000000 00 00000010 0 00 0
0 350 ffffffff 00 00000008 0 00 0
1 350 00000000 00 00000008 0 00 0
4 300 00000008 00 00000010 0 00 0
0 b02 00000016 00 00000000 0 00 0
0 b05 00000026 00 00000000 0 00 0
1 b05 00000000 24 00000027 1 05 0
0 b02 00000026 24 00000017 1 02 0
1 b02 00000000 24 00000027 1 02 0
5 300 00000008 00 00000018 0 00 0
0 347 00000009 00 00000000 0 00 0
4 300 00000008 00 00000010 0 00 0
0 347 00000008 00 00000009 1 02 0
2 b02 00000001 00 00000027 1 05 0
5 b05 00000001 00 00000027 0 00 0
1 b05 00000000 00 00000026 0 00 0

/* sim/clic_tb.sv */
// CLIC CSR testbench
`timescale 1ns/100ps
`default_nettype none

module clic_tb;

  // one access from the golden file
  typedef struct packed {
    logic [2:0] op;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [7:0] lines;
    logic [31:0] exp_rd;
    logic exp_valid;
    logic [7:0] exp_id;
    logic [1:0] mode;
  } golden_row_t;

  logic clk;
  logic rst;
  logic req;
  logic ack;
  decoder_pkg::csr_req_t req_data;
  decoder_pkg::word rdata;
  logic [7:0] irq_lines;
  clic_pkg::irq_t irq;

  golden_row_t rows [$];
  bit loaded = 1'b0;
  int errors = 0;
  // config words as written by the accesses, prio field gives the expected level
  logic [31:0] cfg_model [8];

  clic_top #(
    .VecSize(8)
  ) dut (
    .clk(clk),
    .rst(rst),
    .req(req),
    .ack(ack),
    .req_data(req_data),
    .rdata(rdata),
    .irq_lines(irq_lines),
    .irq(irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic load_golden();
    int fd;
    int fields;
    string line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_lines;
    logic [31:0] f_rd;
    logic [31:0] f_valid;
    logic [31:0] f_id;
    logic [31:0] f_mode;
    golden_row_t row;
    fd = $fopen("sim/clic_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open golden file sim/clic_golden.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // column notes and blank lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_addr, f_wdata,
                           f_lines, f_rd, f_valid, f_id, f_mode);
          if (fields != 8) begin
            $display("golden line could not be parsed: %s", line);
            errors++;
          end else begin
            row.op = f_op[2:0];
            row.addr = f_addr[11:0];
            row.wdata = f_wdata;
            row.lines = f_lines[7:0];
            row.exp_rd = f_rd;
            row.exp_valid = f_valid[0];
            row.exp_id = f_id[7:0];
            row.mode = f_mode[1:0];
            rows.push_back(row);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // csrrw/csrrs/csrrc result, immediate forms zero-extend the low five bits
  function automatic logic [31:0] written_word(input logic [31:0] old,
                                               input logic [2:0] op,
                                               input logic [31:0] wdata);
    logic [31:0] src;
    src = (op >= 3'd3) ? {27'b0, wdata[4:0]} : wdata;
    case (op)
      3'd0, 3'd3: written_word = src;
      3'd1, 3'd4: written_word = old | src;
      3'd2, 3'd5: written_word = old & ~src;
      default: written_word = old;
    endcase
  endfunction

  // full four-phase access, returns the captured read data
  task automatic run_access(input golden_row_t row, output decoder_pkg::word got);
    int gap;
    int hold;
    decoder_pkg::csr_req_t next_req;
    gap = $urandom_range(3, 0);
    hold = $urandom_range(3, 0);
    next_req.addr = row.addr;
    next_req.op = decoder_pkg::csr_t'(row.op);
    // zimm comes from the low bits of the data column
    next_req.rs1_zimm = row.wdata[4:0];
    next_req.rs1_data = row.wdata;
    @(posedge clk);
    irq_lines <= row.lines;
    // lines reach the pending bits before the access
    repeat (3 + gap) @(posedge clk);
    req_data <= next_req;
    req <= 1'b1;
    @(negedge clk);
    while (!ack) begin
      @(negedge clk);
    end
    got = rdata;
    // core stalls with req still high
    repeat (hold) begin
      @(negedge clk);
      if (!ack || rdata != got) begin
        $display("error %0t: ack or rdata moved while req was held high", $time);
        errors++;
      end
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (ack) begin
      @(negedge clk);
    end
  endtask

  task automatic check_rdata(input int idx, input golden_row_t row,
                             input decoder_pkg::word got);
    // mode 1 only bounds the value, count is free running
    if (row.mode == 2'd1) begin
      if (got >= row.exp_rd) begin
        $display("error %0t: access %0d read 0x%08h, expected below 0x%08h",
                 $time, idx, got, row.exp_rd);
        errors++;
      end
    end else if (got != row.exp_rd) begin
      $display("error %0t: access %0d read 0x%08h, expected 0x%08h",
               $time, idx, got, row.exp_rd);
      errors++;
    end
  endtask

  task automatic check_irq(input int idx, input golden_row_t row,
                           input logic [7:0] exp_level);
    if (irq.valid != row.exp_valid) begin
      $display("error %0t: access %0d irq.valid %0b, expected %0b",
               $time, idx, irq.valid, row.exp_valid);
      errors++;
    end else if (row.exp_valid && irq.id != row.exp_id) begin
      // id only means something with valid high
      $display("error %0t: access %0d irq.id %0d, expected %0d",
               $time, idx, irq.id, row.exp_id);
      errors++;
    end else if (row.exp_valid && irq.level != exp_level) begin
      // level is the winner's priority
      $display("error %0t: access %0d irq.level %0d, expected %0d",
               $time, idx, irq.level, exp_level);
      errors++;
    end
  endtask

  // bound scales with the number of accesses
  initial begin
    wait (loaded);
    repeat (rows.size() * 40 + 10) @(posedge clk);
    $display("handshake timed out after %0d cycles", rows.size() * 40 + 10);
    $display("Verification failed");
    $finish;
  end

  initial begin
    decoder_pkg::word got;
    int vec;
    rst <= 1'b1;
    req <= 1'b0;
    req_data <= '0;
    irq_lines <= '0;
    foreach (cfg_model[v]) begin
      cfg_model[v] = '0;
    end
    void'($urandom(32'h1ab6));
    load_golden();
    if (rows.size() == 0) begin
      $display("golden file holds no accesses");
      errors++;
    end
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[i]) begin
      run_access(rows[i], got);
      // mode 2 repeats the read until the expected value shows up
      if (rows[i].mode == 2'd2) begin
        while (got != rows[i].exp_rd) begin
          run_access(rows[i], got);
        end
      end else begin
        check_rdata(i, rows[i], got);
      end
      // track writes into the vector table
      if (rows[i].addr >= clic_pkg::int_cfg_base &&
          rows[i].addr < clic_pkg::int_cfg_base + 12'd8) begin
        vec = int'(rows[i].addr - clic_pkg::int_cfg_base);
        cfg_model[vec] = written_word(cfg_model[vec], rows[i].op, rows[i].wdata);
      end
      // irq two idle cycles after ack falls
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_irq(i, rows[i], cfg_model[rows[i].exp_id[2:0]][9:2]);
    end
    $display("%0d errors in %0d accesses", errors, rows.size());
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
